/* verilog/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// one instruction line as returned by the memory
`define LINE_WIDTH 128

// 32-bit words per line
`define FETCH_WORDS 4

// first fetch address, line aligned
`define RESET_PC 32'h0000_0000

// architectural registers
`define REG_COUNT 32

`endif

/* verilog/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // register form: opcode, rs, rt, rd, shamt, funct
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // immediate form over the same word
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } fetch_data_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   op;
        word_t     a;
        word_t     b;
        reg_addr_t dest;
    } issue_data_t;

    // retire record, also the register write
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } rf_w_t;

    typedef struct packed {
        logic  req;
        word_t addr;
    } imem_req_t;

    // word 0 sits in the low bits of line
    typedef struct packed {
        logic                   ack;
        logic [`LINE_WIDTH-1:0] line;
    } imem_resp_t;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    output core_pkg::imem_req_t   imem_req,
    input  core_pkg::imem_resp_t  imem_resp,
    output core_pkg::fetch_data_t fetch_data
);

    localparam int IDX_W = $clog2(`FETCH_WORDS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_ACK_LOW,
        S_DRAIN
    } state_e;

    state_e                 state;
    state_e                 state_next;
    core_pkg::word_t        line_addr;
    logic [`LINE_WIDTH-1:0] line_buf;
    logic [IDX_W-1:0]       word_idx;
    logic                   last_word;

    assign last_word = (word_idx == IDX_W'(`FETCH_WORDS - 1));

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: state_next = S_REQ;
            S_REQ: begin
                if (imem_resp.ack) begin
                    state_next = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // next request only once the old ack has gone
                if (last_word) begin
                    state_next = imem_resp.ack ? S_ACK_LOW : S_REQ;
                end
            end
            S_ACK_LOW: begin
                if (!imem_resp.ack) begin
                    state_next = S_REQ;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            word_idx  <= '0;
            line_addr <= `RESET_PC;
        end else begin
            state <= state_next;
            if (state == S_DRAIN) begin
                word_idx <= word_idx + 1'b1;
                if (last_word) begin
                    line_addr <= line_addr + core_pkg::word_t'(`FETCH_WORDS * 4);
                end
            end
        end
    end

    // line capture on the first edge with ack seen
    always_ff @(posedge clk) begin
        if (state == S_REQ && imem_resp.ack) begin
            line_buf <= imem_resp.line;
        end
    end

    assign imem_req.req  = (state == S_REQ);
    assign imem_req.addr = line_addr;

    always_comb begin
        fetch_data.valid = (state == S_DRAIN);
        fetch_data.pc    = line_addr + (core_pkg::word_t'(word_idx) << 2);
        fetch_data.instr = line_buf[word_idx * 32 +: 32];
    end

    // memory side of the four-phase handshake
    a_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req.req && imem_resp.ack |=> imem_resp.ack);

    a_line_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_resp.ack |=> !imem_resp.ack || $stable(imem_resp.line));

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::fetch_data_t fetch_data,
    output core_pkg::reg_addr_t   rs_addr,
    output core_pkg::reg_addr_t   rt_addr,
    input  core_pkg::word_t       rs_data,
    input  core_pkg::word_t       rt_data,
    input  core_pkg::rf_w_t       exec_bypass,
    input  core_pkg::rf_w_t       retire_bypass,
    output core_pkg::issue_data_t issue_data
);

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;

    core_pkg::instr_u      instr;
    core_pkg::word_t       rs_val;
    core_pkg::word_t       rt_val;
    core_pkg::issue_data_t issue_next;

    // youngest result wins, r0 is hardwired
    function automatic core_pkg::word_t pick_operand(
        input core_pkg::reg_addr_t addr,
        input core_pkg::word_t     rf_data,
        input core_pkg::rf_w_t     ex,
        input core_pkg::rf_w_t     rt
    );
        if (addr == '0) begin
            return '0;
        end
        if (ex.valid && ex.addr == addr) begin
            return ex.data;
        end
        if (rt.valid && rt.addr == addr) begin
            return rt.data;
        end
        return rf_data;
    endfunction

    assign instr   = fetch_data.instr;
    assign rs_addr = instr.r.rs;
    assign rt_addr = instr.r.rt;

    assign rs_val = pick_operand(rs_addr, rs_data, exec_bypass, retire_bypass);
    assign rt_val = pick_operand(rt_addr, rt_data, exec_bypass, retire_bypass);

    always_comb begin
        issue_next       = '0;
        issue_next.valid = fetch_data.valid;
        issue_next.pc    = fetch_data.pc;
        issue_next.a     = rs_val;
        case (instr.r.opcode)
            OP_RTYPE: begin
                issue_next.b    = rt_val;
                issue_next.dest = instr.r.rd;
                case (instr.r.funct)
                    FN_ADDU: issue_next.op = core_pkg::ALU_ADD;
                    FN_SUBU: issue_next.op = core_pkg::ALU_SUB;
                    FN_AND:  issue_next.op = core_pkg::ALU_AND;
                    FN_OR:   issue_next.op = core_pkg::ALU_OR;
                    FN_XOR:  issue_next.op = core_pkg::ALU_XOR;
                    FN_SLT:  issue_next.op = core_pkg::ALU_SLT;
                    default: issue_next.op = core_pkg::ALU_NONE;
                endcase
            end
            OP_ADDIU: begin
                issue_next.op   = core_pkg::ALU_ADD;
                issue_next.b    = {{16{instr.i.imm[15]}}, instr.i.imm};
                issue_next.dest = instr.i.rt;
            end
            OP_ORI: begin
                issue_next.op   = core_pkg::ALU_OR;
                issue_next.b    = {16'h0000, instr.i.imm};
                issue_next.dest = instr.i.rt;
            end
            OP_LUI: begin
                issue_next.op   = core_pkg::ALU_LUI;
                issue_next.b    = {instr.i.imm, 16'h0000};
                issue_next.dest = instr.i.rt;
            end
            default: issue_next.op = core_pkg::ALU_NONE;
        endcase
        // unknown words still flow but write nothing
        if (issue_next.op == core_pkg::ALU_NONE) begin
            issue_next.dest = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_data <= '0;
        end else begin
            issue_data <= issue_next;
        end
    end

    // the execute bypass always belongs to the last issue
    a_bypass_is_last_issue: assert property (@(posedge clk) disable iff (!rst_n)
        exec_bypass.valid |-> issue_data.valid && exec_bypass.addr == issue_data.dest);

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  core_pkg::issue_data_t issue_data,
    output core_pkg::rf_w_t       exec_bypass,
    output core_pkg::rf_w_t       rfw,
    output core_pkg::word_t       rt_pc
);

    core_pkg::word_t result;

    always_comb begin
        case (issue_data.op)
            core_pkg::ALU_ADD: result = issue_data.a + issue_data.b;
            core_pkg::ALU_SUB: result = issue_data.a - issue_data.b;
            core_pkg::ALU_AND: result = issue_data.a & issue_data.b;
            core_pkg::ALU_OR:  result = issue_data.a | issue_data.b;
            core_pkg::ALU_XOR: result = issue_data.a ^ issue_data.b;
            // signed compare, 1 or 0
            core_pkg::ALU_SLT: begin
                result = ($signed(issue_data.a) < $signed(issue_data.b)) ? 32'd1 : 32'd0;
            end
            core_pkg::ALU_LUI: result = issue_data.b;
            default:           result = '0;
        endcase
    end

    // same-cycle result for decode forwarding
    always_comb begin
        exec_bypass.valid = issue_data.valid && (issue_data.dest != '0);
        exec_bypass.addr  = issue_data.dest;
        exec_bypass.data  = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rfw   <= '0;
            rt_pc <= '0;
        end else begin
            rfw   <= exec_bypass;
            rt_pc <= issue_data.pc;
        end
    end

    // a write with no operation would store zero
    a_dest_has_op: assert property (@(posedge clk) disable iff (!rst_n)
        issue_data.valid && issue_data.dest != '0 |-> issue_data.op != core_pkg::ALU_NONE);

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::rf_w_t     write,
    input  core_pkg::reg_addr_t ra0,
    input  core_pkg::reg_addr_t ra1,
    output core_pkg::word_t     rd0,
    output core_pkg::word_t     rd1
);

    core_pkg::word_t regs [`REG_COUNT];

    // r0 is cleared by reset and never written afterwards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write.valid && write.addr != '0) begin
            regs[write.addr] <= write.data;
        end
    end

    // same-cycle writes are covered by the retire bypass in decode
    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

/* verilog/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    output core_pkg::imem_req_t  imem_req,
    input  core_pkg::imem_resp_t imem_resp,
    output core_pkg::rf_w_t      rfw_out,
    output core_pkg::word_t      rt_pc_out
);

    core_pkg::fetch_data_t fetch_data;
    core_pkg::issue_data_t issue_data;
    core_pkg::rf_w_t       exec_bypass;
    core_pkg::reg_addr_t   rs_addr;
    core_pkg::reg_addr_t   rt_addr;
    core_pkg::word_t       rs_data;
    core_pkg::word_t       rt_data;

    fetch_stage u_fetch (
        .clk,
        .rst_n,
        .imem_req,
        .imem_resp,
        .fetch_data
    );

    // retire record doubles as the second bypass source
    decode_stage u_decode (
        .clk,
        .rst_n,
        .fetch_data,
        .rs_addr,
        .rt_addr,
        .rs_data,
        .rt_data,
        .exec_bypass,
        .retire_bypass (rfw_out),
        .issue_data
    );

    execute_stage u_execute (
        .clk,
        .rst_n,
        .issue_data,
        .exec_bypass,
        .rfw   (rfw_out),
        .rt_pc (rt_pc_out)
    );

    regfile u_regfile (
        .clk,
        .rst_n,
        .write (rfw_out),
        .ra0   (rs_addr),
        .ra1   (rt_addr),
        .rd0   (rs_data),
        .rd1   (rt_data)
    );

endmodule

/* tests/tb_datapath.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_datapath;

    localparam int PROG_WORDS      = 256;
    localparam int EXP_MAX         = 64;
    localparam int RESET_LIMIT     = 64;
    localparam int HANDSHAKE_LIMIT = 64;
    localparam int RETIRE_LIMIT    = 128;
    localparam int TAIL_CYCLES     = 80;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    core_pkg::imem_req_t  imem_req;
    core_pkg::imem_resp_t imem_resp = '0;
    core_pkg::rf_w_t      rfw_out;
    core_pkg::word_t      rt_pc_out;

    // program image and expected retire records from the stimulus file
    logic [31:0]         prog_mem [PROG_WORDS];
    int                  prog_count = 0;
    core_pkg::word_t     exp_pc [EXP_MAX];
    core_pkg::reg_addr_t exp_addr [EXP_MAX];
    core_pkg::word_t     exp_data [EXP_MAX];
    int                  exp_count = 0;

    logic [15:0] lfsr = 16'd50;
    int          value_errors = 0;
    int          other_errors = 0;
    int          retired = 0;
    logic        aborted = 1'b0;
    logic        run_done = 1'b0;

    datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_req  (imem_req),
        .imem_resp (imem_resp),
        .rfw_out   (rfw_out),
        .rt_pc_out (rt_pc_out)
    );

    always #2 clk = ~clk;

    // Galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // three bits, one step each, so 0 to 7 cycles
    function automatic int unsigned random_delay();
        int unsigned delay;
        delay = 0;
        for (int b = 0; b < 3; b++) begin
            delay = (delay << 1) | {31'd0, lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
        return delay;
    endfunction

    // words past the end of the program read as zero
    function automatic logic [`LINE_WIDTH-1:0] read_line(input logic [31:0] addr);
        logic [`LINE_WIDTH-1:0] line;
        int unsigned            idx;
        line = '0;
        for (int k = 0; k < `FETCH_WORDS; k++) begin
            idx = (addr >> 2) + 32'(k);
            if (idx < 32'(prog_count)) begin
                line[k*32 +: 32] = prog_mem[idx[7:0]];
            end
        end
        return line;
    endfunction

    task automatic load_stimulus(output logic ok);
        int          fd;
        int          n;
        string       text;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        ok = 1'b0;
        fd = $fopen("tests/datapath_stimulus.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file could not be opened");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0 && text.getc(0) == "I") begin
                    if ($sscanf(text, "I %h", f0) == 1 && prog_count < PROG_WORDS) begin
                        prog_mem[prog_count] = f0;
                        prog_count++;
                    end
                end else if (n > 0 && text.getc(0) == "E") begin
                    if ($sscanf(text, "E %h %h %h", f0, f1, f2) == 3 && exp_count < EXP_MAX) begin
                        exp_pc[exp_count]   = f0;
                        exp_addr[exp_count] = f1[4:0];
                        exp_data[exp_count] = f2;
                        exp_count++;
                    end
                end
            end
            $fclose(fd);
            if (prog_count == 0 || exp_count == 0) begin
                $display("the stimulus file holds no program words or no expected retires");
                other_errors++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // nothing may request or retire while reset is held
    task automatic check_reset_window();
        repeat (16) begin
            @(negedge clk);
            if (imem_req.req !== 1'b0) begin
                $display("Fail imem_req.req expected %h got %h", 1'b0, imem_req.req);
                value_errors++;
            end
            if (rfw_out.valid !== 1'b0) begin
                $display("Fail rfw_out.valid expected %h got %h", 1'b0, rfw_out.valid);
                value_errors++;
            end
        end
    endtask

    task automatic check_retires();
        int waited;
        for (int k = 0; k < exp_count && !aborted; k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (rfw_out.valid !== 1'b1 && waited < RETIRE_LIMIT && !aborted);
            if (rfw_out.valid === 1'b1) begin
                if (rt_pc_out !== exp_pc[k]) begin
                    $display("Fail rt_pc_out retire %0d expected %h got %h",
                             k, exp_pc[k], rt_pc_out);
                    value_errors++;
                end
                if (rfw_out.addr !== exp_addr[k]) begin
                    $display("Fail rfw_out.addr retire %0d expected %h got %h",
                             k, exp_addr[k], rfw_out.addr);
                    value_errors++;
                end
                if (rfw_out.data !== exp_data[k]) begin
                    $display("Fail rfw_out.data retire %0d expected %h got %h",
                             k, exp_data[k], rfw_out.data);
                    value_errors++;
                end
                retired++;
            end else if (!aborted) begin
                $display("timeout: retire %0d with pc %h never appeared", k, exp_pc[k]);
                other_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    // zero words keep coming, none of them may retire
    task automatic check_quiet_tail();
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            if (rfw_out.valid === 1'b1) begin
                $display("a retire appeared after the last expected one, pc %h", rt_pc_out);
                other_errors++;
            end
        end
    endtask

    // instruction memory, four-phase req/ack with random delays
    initial begin : memory_model
        int          waited;
        int unsigned delay;
        logic [31:0] req_addr;
        logic        first_req;
        first_req = 1'b1;
        waited    = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            other_errors++;
            aborted = 1'b1;
        end
        while (!aborted && !run_done) begin
            waited = 0;
            while (imem_req.req !== 1'b1 && waited < HANDSHAKE_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (imem_req.req !== 1'b1) begin
                $display("timeout: fetch raised no instruction request");
                other_errors++;
                aborted = 1'b1;
            end else begin
                req_addr = imem_req.addr;
                if (first_req && req_addr !== 32'h0000_0000) begin
                    $display("Fail imem_req.addr expected %h got %h", 32'h0000_0000, req_addr);
                    value_errors++;
                end
                first_req = 1'b0;
                delay     = random_delay();
                repeat (delay) @(negedge clk);
                @(posedge clk);
                imem_resp.line <= read_line(req_addr);
                imem_resp.ack  <= 1'b1;
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (imem_req.req === 1'b1 && waited < HANDSHAKE_LIMIT);
                if (imem_req.req === 1'b1) begin
                    $display("timeout: fetch never dropped its request after ack");
                    other_errors++;
                    aborted = 1'b1;
                end else begin
                    delay = random_delay();
                    repeat (delay) @(negedge clk);
                    @(posedge clk);
                    imem_resp.ack <= 1'b0;
                end
            end
        end
    end

    initial begin : main_flow
        logic stim_ok;
        load_stimulus(stim_ok);
        if (stim_ok) begin
            check_reset_window();
            @(posedge clk);
            rst_n <= 1'b1;
            check_retires();
            if (!aborted) begin
                check_quiet_tail();
            end
        end
        run_done = 1'b1;
        $display("checked %0d of %0d retires, %0d value errors, %0d other errors",
                 retired, exp_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tests/datapath_stimulus.txt */
# I <word>: program word in hex, placed in order from address 0
# E <pc> <reg> <data>: expected retire in program order, all hex
I 3c011234  lui   r1, 0x1234
I 34215678  ori   r1, r1, 0x5678
I 2402ffff  addiu r2, r0, -1
I 00221821  addu  r3, r1, r2
I 00232023  subu  r4, r1, r3
I 0044282a  slt   r5, r2, r4
I 0082302a  slt   r6, r4, r2
I 00223824  and   r7, r1, r2
I 00854025  or    r8, r4, r5
I 00274826  xor   r9, r1, r7
I 24200005  addiu r0, r1, 5
I 00000000  zero word
I 8c0a0004  unsupported opcode 0x23
I 00015021  addu  r10, r0, r1
I 240b7fff  addiu r11, r0, 0x7fff
I 356c8000  ori   r12, r11, 0x8000
I 258d8000  addiu r13, r12, -0x8000
I 000d7023  subu  r14, r0, r13
I 01cd782a  slt   r15, r14, r13
I 01cf8026  xor   r16, r14, r15
E 00000000 01 12340000
E 00000004 01 12345678
E 00000008 02 ffffffff
E 0000000c 03 12345677
E 00000010 04 00000001
E 00000014 05 00000001
E 00000018 06 00000000
E 0000001c 07 12345678
E 00000020 08 00000001
E 00000024 09 00000000
E 00000034 0a 12345678
E 00000038 0b 00007fff
E 0000003c 0c 0000ffff
E 00000040 0d 00007fff
E 00000044 0e ffff8001
E 00000048 0f 00000001
E 0000004c 10 ffff8000

/* build.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/regfile.sv
verilog/datapath.sv
tests/tb_datapath.sv

/* run_sim.sh */
#!/bin/sh
# build the datapath testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_datapath -f build.f \
    || { echo "verilator build failed"; exit 1; }
out=$(obj_dir/Vtb_datapath 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
